/* hw/axi_demux_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI demux widths, address map constants and channel structs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package axi_demux_pkg;

  // Bus widths shared by every block of the demux
  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned STRB_WIDTH = DATA_WIDTH / 8;
  localparam int unsigned ID_WIDTH   = 4;
  // Burst length is stored as beats minus one, as on the AXI bus
  localparam int unsigned LEN_WIDTH  = 8;

  // The port field sits in address bits 13:12, one 4 KiB window per port
  localparam int unsigned PORT_LSB   = 12;
  localparam int unsigned PORT_WIDTH = 2;

  // Response codes used on B and R
  localparam logic [1:0] RESP_OKAY   = 2'd0;
  localparam logic [1:0] RESP_DECERR = 2'd3;

  // Write address channel, bursts are always INCR at full bus width
  typedef struct packed {
    logic [ID_WIDTH-1:0]   id;
    logic [ADDR_WIDTH-1:0] addr;
    logic [LEN_WIDTH-1:0]  len;
  } aw_chan_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic [STRB_WIDTH-1:0] strb;
    logic                  last;
  } w_chan_t;

  typedef struct packed {
    logic [ID_WIDTH-1:0] id;
    logic [1:0]          resp;
  } b_chan_t;

  // Read address channel carries the same fields as AW
  typedef struct packed {
    logic [ID_WIDTH-1:0]   id;
    logic [ADDR_WIDTH-1:0] addr;
    logic [LEN_WIDTH-1:0]  len;
  } ar_chan_t;

  typedef struct packed {
    logic [ID_WIDTH-1:0]   id;
    logic [DATA_WIDTH-1:0] data;
    logic [1:0]            resp;
    logic                  last;
  } r_chan_t;

  // Everything that flows from a master towards a slave
  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
    ar_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } axi_req_t;

  // Everything that flows from a slave back to its master
  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    b_chan_t b;
    logic    b_valid;
    logic    ar_ready;
    r_chan_t r;
    logic    r_valid;
  } axi_resp_t;

endpackage

`default_nettype wire

/* hw/axi_addr_decode.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fixed address map decoder
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module axi_addr_decode import axi_demux_pkg::*; #(
  parameter  int unsigned NUM_MST_PORTS = 3,
  // One extra select value is reserved for the error responder
  localparam int unsigned SEL_WIDTH     = $clog2(NUM_MST_PORTS + 1)
) (
  input  logic [ADDR_WIDTH-1:0] addr_i,
  output logic [SEL_WIDTH-1:0]  sel_o
);

  logic [PORT_WIDTH-1:0] port_field;
  logic                  upper_zero;
  logic                  port_mapped;

  // Port number is taken straight from the window bits
  assign port_field = addr_i[PORT_LSB +: PORT_WIDTH];

  // Only the lowest 16 KiB are mapped at all
  assign upper_zero = (addr_i[ADDR_WIDTH-1:PORT_LSB+PORT_WIDTH] == '0);

  // Windows above the last real port are holes in the map
  assign port_mapped = (32'(port_field) < NUM_MST_PORTS);

  always_comb begin
    if (upper_zero && port_mapped) begin
      sel_o = SEL_WIDTH'(port_field);
    end else begin
      // Anything unmapped is steered to the error responder
      sel_o = SEL_WIDTH'(NUM_MST_PORTS);
    end
  end

endmodule

`default_nettype wire

/* hw/axi_demux_write.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Write path router for AW, W and B
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module axi_demux_write import axi_demux_pkg::*; #(
  parameter  int unsigned NUM_MST_PORTS = 3,
  parameter  int unsigned MAX_TRANS     = 4,
  localparam int unsigned SEL_WIDTH     = $clog2(NUM_MST_PORTS + 1),
  localparam int unsigned CNT_WIDTH     = $clog2(MAX_TRANS + 1)
) (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  axi_req_t                     slv_req_i,
  input  logic [SEL_WIDTH-1:0]         aw_sel_i,
  output axi_resp_t                    slv_resp_o,
  // Entry NUM_MST_PORTS is the error responder
  output axi_req_t  [NUM_MST_PORTS:0]  mst_reqs_o,
  input  axi_resp_t [NUM_MST_PORTS:0]  mst_resps_i
);

  // Target of every write still in flight
  logic [SEL_WIDTH-1:0] cur_target_q;
  // Bursts accepted on AW but not yet answered on B
  logic [CNT_WIDTH-1:0] wr_cnt_q;
  // Bursts accepted on AW whose W data has not finished yet
  logic [CNT_WIDTH-1:0] w_pend_q;

  logic aw_allow;
  logic w_open;
  logic b_open;
  logic aw_ready;
  logic w_ready;
  logic b_valid;
  logic aw_hs;
  logic w_last_hs;
  logic b_hs;

  // A new burst may go out if nothing is pending, or if it heads to the same
  // target and there is still room in the counter
  assign aw_allow = (wr_cnt_q == '0) ||
                    ((aw_sel_i == cur_target_q) && (32'(wr_cnt_q) < MAX_TRANS));

  // W may only flow for bursts whose address has already been taken
  assign w_open = (w_pend_q != '0);

  // B is only expected while something is outstanding
  assign b_open = (wr_cnt_q != '0);

  assign aw_ready = aw_allow && mst_resps_i[aw_sel_i].aw_ready;
  assign w_ready  = w_open && mst_resps_i[cur_target_q].w_ready;
  assign b_valid  = b_open && mst_resps_i[cur_target_q].b_valid;

  assign aw_hs     = slv_req_i.aw_valid && aw_ready;
  assign w_last_hs = slv_req_i.w_valid && w_ready && slv_req_i.w.last;
  assign b_hs      = b_valid && slv_req_i.b_ready;

  // Payload is broadcast, only the valid and ready lines are steered
  always_comb begin
    for (int unsigned i = 0; i <= NUM_MST_PORTS; i++) begin
      mst_reqs_o[i]          = '0;
      mst_reqs_o[i].aw       = slv_req_i.aw;
      mst_reqs_o[i].w        = slv_req_i.w;
      mst_reqs_o[i].aw_valid = slv_req_i.aw_valid && aw_allow &&
                               (aw_sel_i == SEL_WIDTH'(i));
      mst_reqs_o[i].w_valid  = slv_req_i.w_valid && w_open &&
                               (cur_target_q == SEL_WIDTH'(i));
      mst_reqs_o[i].b_ready  = slv_req_i.b_ready && b_open &&
                               (cur_target_q == SEL_WIDTH'(i));
    end
  end

  // The read half of this response stays at zero and is filled in at the top
  always_comb begin
    slv_resp_o          = '0;
    slv_resp_o.aw_ready = aw_ready;
    slv_resp_o.w_ready  = w_ready;
    slv_resp_o.b        = mst_resps_i[cur_target_q].b;
    slv_resp_o.b_valid  = b_valid;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cur_target_q <= '0;
      wr_cnt_q     <= '0;
      w_pend_q     <= '0;
    end else begin
      // The target only changes while the counter is empty, so latching it on
      // every accepted burst is safe
      if (aw_hs) begin
        cur_target_q <= aw_sel_i;
      end
      wr_cnt_q <= wr_cnt_q + CNT_WIDTH'(aw_hs) - CNT_WIDTH'(b_hs);
      w_pend_q <= w_pend_q + CNT_WIDTH'(aw_hs) - CNT_WIDTH'(w_last_hs);
    end
  end

endmodule

`default_nettype wire

/* hw/axi_demux_read.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Read path router for AR and R
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module axi_demux_read import axi_demux_pkg::*; #(
  parameter  int unsigned NUM_MST_PORTS = 3,
  parameter  int unsigned MAX_TRANS     = 4,
  localparam int unsigned SEL_WIDTH     = $clog2(NUM_MST_PORTS + 1),
  localparam int unsigned CNT_WIDTH     = $clog2(MAX_TRANS + 1)
) (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  axi_req_t                     slv_req_i,
  input  logic [SEL_WIDTH-1:0]         ar_sel_i,
  output axi_resp_t                    slv_resp_o,
  // Entry NUM_MST_PORTS is the error responder
  output axi_req_t  [NUM_MST_PORTS:0]  mst_reqs_o,
  input  axi_resp_t [NUM_MST_PORTS:0]  mst_resps_i
);

  // Target shared by all reads in flight
  logic [SEL_WIDTH-1:0] cur_target_q;
  // Read bursts that have not yet delivered their last beat
  logic [CNT_WIDTH-1:0] rd_cnt_q;

  logic ar_allow;
  logic r_open;
  logic ar_ready;
  logic r_valid;
  logic ar_hs;
  logic r_last_hs;

  // Same rule as on the write side, one target at a time
  assign ar_allow = (rd_cnt_q == '0) ||
                    ((ar_sel_i == cur_target_q) && (32'(rd_cnt_q) < MAX_TRANS));

  assign r_open = (rd_cnt_q != '0);

  assign ar_ready = ar_allow && mst_resps_i[ar_sel_i].ar_ready;
  assign r_valid  = r_open && mst_resps_i[cur_target_q].r_valid;

  assign ar_hs     = slv_req_i.ar_valid && ar_ready;
  assign r_last_hs = r_valid && slv_req_i.r_ready && mst_resps_i[cur_target_q].r.last;

  always_comb begin
    for (int unsigned i = 0; i <= NUM_MST_PORTS; i++) begin
      mst_reqs_o[i]          = '0;
      mst_reqs_o[i].ar       = slv_req_i.ar;
      mst_reqs_o[i].ar_valid = slv_req_i.ar_valid && ar_allow &&
                               (ar_sel_i == SEL_WIDTH'(i));
      // Only the port that owns the open bursts sees r_ready
      mst_reqs_o[i].r_ready  = slv_req_i.r_ready && r_open &&
                               (cur_target_q == SEL_WIDTH'(i));
    end
  end

  // Write fields of this response stay at zero
  always_comb begin
    slv_resp_o          = '0;
    slv_resp_o.ar_ready = ar_ready;
    slv_resp_o.r        = mst_resps_i[cur_target_q].r;
    slv_resp_o.r_valid  = r_valid;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cur_target_q <= '0;
      rd_cnt_q     <= '0;
    end else begin
      if (ar_hs) begin
        cur_target_q <= ar_sel_i;
      end
      // A burst is done once its last beat has been taken
      rd_cnt_q <= rd_cnt_q + CNT_WIDTH'(ar_hs) - CNT_WIDTH'(r_last_hs);
    end
  end

endmodule

`default_nettype wire

/* hw/axi_err_slave.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decode error responder for writes and reads
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module axi_err_slave import axi_demux_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  input  axi_req_t  req_i,
  output axi_resp_t resp_o
);

  typedef enum logic [1:0] {
    W_IDLE,
    W_DATA,
    W_RESP
  } wr_state_e;

  typedef enum logic {
    R_IDLE,
    R_DATA
  } rd_state_e;

  wr_state_e wr_state_q;
  rd_state_e rd_state_q;

  // Ids and length of the burst being answered
  logic [ID_WIDTH-1:0]  b_id_q;
  logic [ID_WIDTH-1:0]  r_id_q;
  logic [LEN_WIDTH-1:0] r_len_q;
  // Beats already sent for the current read
  logic [LEN_WIDTH-1:0] r_beat_q;

  logic r_last;

  assign r_last = (r_beat_q == r_len_q);

  // Handshake lines follow the state, no data is ever stored
  always_comb begin
    resp_o          = '0;
    resp_o.aw_ready = (wr_state_q == W_IDLE);
    resp_o.w_ready  = (wr_state_q == W_DATA);
    resp_o.b.id     = b_id_q;
    resp_o.b.resp   = RESP_DECERR;
    resp_o.b_valid  = (wr_state_q == W_RESP);
    resp_o.ar_ready = (rd_state_q == R_IDLE);
    resp_o.r.id     = r_id_q;
    resp_o.r.data   = '0;
    resp_o.r.resp   = RESP_DECERR;
    resp_o.r.last   = r_last;
    resp_o.r_valid  = (rd_state_q == R_DATA);
  end

  // Write side takes one burst, drops its data and then answers
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_state_q <= W_IDLE;
    end else begin
      case (wr_state_q)
        W_IDLE: begin
          if (req_i.aw_valid) begin
            wr_state_q <= W_DATA;
          end
        end
        W_DATA: begin
          // B goes out on the cycle after the last beat
          if (req_i.w_valid && req_i.w.last) begin
            wr_state_q <= W_RESP;
          end
        end
        W_RESP: begin
          if (req_i.b_ready) begin
            wr_state_q <= W_IDLE;
          end
        end
        default: begin
          wr_state_q <= W_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if ((wr_state_q == W_IDLE) && req_i.aw_valid) begin
      b_id_q <= req_i.aw.id;
    end
  end

  // Read side sends len+1 zero beats, one per cycle while r_ready is high
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_state_q <= R_IDLE;
      r_beat_q   <= '0;
    end else begin
      case (rd_state_q)
        R_IDLE: begin
          if (req_i.ar_valid) begin
            rd_state_q <= R_DATA;
            r_beat_q   <= '0;
          end
        end
        R_DATA: begin
          if (req_i.r_ready) begin
            if (r_last) begin
              rd_state_q <= R_IDLE;
            end else begin
              r_beat_q <= r_beat_q + 1'b1;
            end
          end
        end
        default: begin
          rd_state_q <= R_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if ((rd_state_q == R_IDLE) && req_i.ar_valid) begin
      r_id_q  <= req_i.ar.id;
      r_len_q <= req_i.ar.len;
    end
  end

endmodule

`default_nettype wire

/* hw/axi_demux_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI demux top with decoders, routers and error port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module axi_demux_top import axi_demux_pkg::*; #(
  parameter  int unsigned NUM_MST_PORTS = 3,
  parameter  int unsigned MAX_TRANS     = 4,
  localparam int unsigned SEL_WIDTH     = $clog2(NUM_MST_PORTS + 1)
) (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  axi_req_t                       slv_req_i,
  output axi_resp_t                      slv_resp_o,
  output axi_req_t  [NUM_MST_PORTS-1:0]  mst_reqs_o,
  input  axi_resp_t [NUM_MST_PORTS-1:0]  mst_resps_i
);

  logic [SEL_WIDTH-1:0] aw_sel;
  logic [SEL_WIDTH-1:0] ar_sel;

  // Each router drives its own half, the other half is left at zero
  axi_req_t  [NUM_MST_PORTS:0] wr_reqs;
  axi_req_t  [NUM_MST_PORTS:0] rd_reqs;
  axi_req_t  [NUM_MST_PORTS:0] all_reqs;
  axi_resp_t [NUM_MST_PORTS:0] all_resps;
  axi_resp_t                   wr_resp;
  axi_resp_t                   rd_resp;
  axi_resp_t                   err_resp;

  axi_addr_decode #(.NUM_MST_PORTS(NUM_MST_PORTS)) u_aw_decode (
    .addr_i (slv_req_i.aw.addr),
    .sel_o  (aw_sel)
  );

  axi_addr_decode #(.NUM_MST_PORTS(NUM_MST_PORTS)) u_ar_decode (
    .addr_i (slv_req_i.ar.addr),
    .sel_o  (ar_sel)
  );

  axi_demux_write #(.NUM_MST_PORTS(NUM_MST_PORTS), .MAX_TRANS(MAX_TRANS)) u_write (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .slv_req_i   (slv_req_i),
    .aw_sel_i    (aw_sel),
    .slv_resp_o  (wr_resp),
    .mst_reqs_o  (wr_reqs),
    .mst_resps_i (all_resps)
  );

  axi_demux_read #(.NUM_MST_PORTS(NUM_MST_PORTS), .MAX_TRANS(MAX_TRANS)) u_read (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .slv_req_i   (slv_req_i),
    .ar_sel_i    (ar_sel),
    .slv_resp_o  (rd_resp),
    .mst_reqs_o  (rd_reqs),
    .mst_resps_i (all_resps)
  );

  // The error responder sits on the highest index
  axi_err_slave u_err_slave (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .req_i   (all_reqs[NUM_MST_PORTS]),
    .resp_o  (err_resp)
  );

  assign all_resps = {err_resp, mst_resps_i};

  // Join write and read halves of every request
  for (genvar i = 0; i <= NUM_MST_PORTS; i++) begin : g_merge
    assign all_reqs[i].aw       = wr_reqs[i].aw;
    assign all_reqs[i].aw_valid = wr_reqs[i].aw_valid;
    assign all_reqs[i].w        = wr_reqs[i].w;
    assign all_reqs[i].w_valid  = wr_reqs[i].w_valid;
    assign all_reqs[i].b_ready  = wr_reqs[i].b_ready;
    assign all_reqs[i].ar       = rd_reqs[i].ar;
    assign all_reqs[i].ar_valid = rd_reqs[i].ar_valid;
    assign all_reqs[i].r_ready  = rd_reqs[i].r_ready;
  end

  assign mst_reqs_o = all_reqs[NUM_MST_PORTS-1:0];

  // Slave response takes write fields from one router and read fields from the other
  assign slv_resp_o.aw_ready = wr_resp.aw_ready;
  assign slv_resp_o.w_ready  = wr_resp.w_ready;
  assign slv_resp_o.b        = wr_resp.b;
  assign slv_resp_o.b_valid  = wr_resp.b_valid;
  assign slv_resp_o.ar_ready = rd_resp.ar_ready;
  assign slv_resp_o.r        = rd_resp.r;
  assign slv_resp_o.r_valid  = rd_resp.r_valid;

endmodule

`default_nettype wire

/* sim/axi_mem_model.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI memory target with random ready stalls
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module axi_mem_model import axi_demux_pkg::*; #(
  parameter int unsigned PORT = 0
) (
  input  logic      clk_i,
  input  logic      reset_i,
  input  axi_req_t  req_i,
  output axi_resp_t resp_o
);

  // One 4 KiB window of words
  logic [DATA_WIDTH-1:0] mem [0:1023];

  // Accepted bursts wait in rings of eight, the demux keeps at most four open
  logic [ID_WIDTH-1:0]  aw_id   [0:7];
  logic [9:0]           aw_word [0:7];
  logic [ID_WIDTH-1:0]  b_id    [0:7];
  logic [ID_WIDTH-1:0]  ar_id   [0:7];
  logic [9:0]           ar_word [0:7];
  logic [LEN_WIDTH-1:0] ar_len  [0:7];
  logic [2:0]           aw_wp;
  logic [2:0]           aw_rp;
  logic [2:0]           b_wp;
  logic [2:0]           b_rp;
  logic [2:0]           ar_wp;
  logic [2:0]           ar_rp;
  logic [LEN_WIDTH-1:0] w_beat;
  logic [LEN_WIDTH-1:0] r_beat;
  logic                 aw_rdy;
  logic                 w_rdy;
  logic                 ar_rdy;
  integer               seed = 67874;

  // Start value of every word is a hash of its full byte address
  initial begin
    for (int i = 0; i < 1024; i++) begin
      mem[i] = ((32'(PORT) << 12) | (32'(i) << 2)) * 32'h9E37_79B1;
    end
  end

  always_comb begin
    resp_o          = '0;
    resp_o.aw_ready = aw_rdy;
    // W is only taken once its address is known
    resp_o.w_ready  = w_rdy && (aw_wp != aw_rp);
    resp_o.b.id     = b_id[b_rp];
    resp_o.b.resp   = RESP_OKAY;
    resp_o.b_valid  = (b_wp != b_rp);
    resp_o.ar_ready = ar_rdy;
    resp_o.r.id     = ar_id[ar_rp];
    resp_o.r.data   = mem[ar_word[ar_rp] + 10'(r_beat)];
    resp_o.r.resp   = RESP_OKAY;
    resp_o.r.last   = (r_beat == ar_len[ar_rp]);
    resp_o.r_valid  = (ar_wp != ar_rp);
  end

  always @(posedge clk_i) begin
    if (reset_i) begin
      {aw_wp, aw_rp, b_wp, b_rp, ar_wp, ar_rp} <= '0;
      w_beat <= '0;
      r_beat <= '0;
      {aw_rdy, w_rdy, ar_rdy} <= '0;
    end else begin
      // Ready is high about three cycles in four
      aw_rdy <= (($random(seed) & 3) != 0);
      w_rdy  <= (($random(seed) & 3) != 0);
      ar_rdy <= (($random(seed) & 3) != 0);
      if (req_i.aw_valid && resp_o.aw_ready) begin
        aw_id[aw_wp]   <= req_i.aw.id;
        aw_word[aw_wp] <= req_i.aw.addr[11:2];
        aw_wp          <= aw_wp + 3'd1;
      end
      if (req_i.w_valid && resp_o.w_ready) begin
        mem[aw_word[aw_rp] + 10'(w_beat)] <= req_i.w.data;
        if (req_i.w.last) begin
          // Burst is complete so its B is queued
          b_id[b_wp] <= aw_id[aw_rp];
          b_wp       <= b_wp + 3'd1;
          aw_rp      <= aw_rp + 3'd1;
          w_beat     <= '0;
        end else begin
          w_beat <= w_beat + 1'b1;
        end
      end
      if (resp_o.b_valid && req_i.b_ready) begin
        b_rp <= b_rp + 3'd1;
      end
      if (req_i.ar_valid && resp_o.ar_ready) begin
        ar_id[ar_wp]   <= req_i.ar.id;
        ar_word[ar_wp] <= req_i.ar.addr[11:2];
        ar_len[ar_wp]  <= req_i.ar.len;
        ar_wp          <= ar_wp + 3'd1;
      end
      if (resp_o.r_valid && req_i.r_ready) begin
        if (resp_o.r.last) begin
          ar_rp  <= ar_rp + 3'd1;
          r_beat <= '0;
        end else begin
          r_beat <= r_beat + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* sim/tb_axi_demux.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the AXI demux with memory targets,
// shadow memory, response assertions and timeout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module tb_axi_demux import axi_demux_pkg::*; ();

  localparam int unsigned NUM_PORTS      = 3;
  localparam int unsigned MAX_TRANS      = 4;
  localparam int unsigned CLK_PERIOD     = 8;
  localparam int unsigned RST_CYCLES     = 10;
  // The whole sequence needs roughly 1500 cycles
  localparam int unsigned TIMEOUT_CYCLES = 4000;
  localparam int unsigned NUM_VALID      = 2 + 3 * NUM_PORTS;

  logic                           clk_i = 1'b0;
  logic                           reset_i = 1'b1;
  axi_req_t                       req_drv;
  logic                           b_rdy = 1'b0;
  logic                           r_rdy = 1'b0;
  axi_req_t                       slv_req;
  axi_resp_t                      slv_resp;
  axi_req_t  [NUM_PORTS-1:0]      mst_reqs;
  axi_resp_t [NUM_PORTS-1:0]      mst_resps;

  // Expected contents of all mapped words, indexed by address bits 13:2
  logic [DATA_WIDTH-1:0] shadow [0:4095];
  // Expected B and R in request order
  b_chan_t               exp_b [0:255];
  r_chan_t               exp_r [0:255];
  logic [7:0]            b_head;
  logic [7:0]            b_tail;
  logic [7:0]            r_head;
  logic [7:0]            r_tail;
  int                    aw_issued = 0;
  int                    ar_issued = 0;
  int                    b_count;
  int                    r_last_count;
  int                    cycle_cnt = 0;
  integer                seed = 67874;
  // Back-pressure has its own sequence, apart from the write data
  integer                rdy_seed = 67874;
  string                 test_name;
  logic                  b_hs;
  logic                  r_hs;
  logic [NUM_VALID-1:0]  valid_bits;

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  axi_demux_top #(.NUM_MST_PORTS(NUM_PORTS), .MAX_TRANS(MAX_TRANS)) u_axi_demux_top (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .slv_req_i   (slv_req),
    .slv_resp_o  (slv_resp),
    .mst_reqs_o  (mst_reqs),
    .mst_resps_i (mst_resps)
  );

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_mem
    axi_mem_model #(.PORT(p)) u_mem_model (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .req_i   (mst_reqs[p]),
      .resp_o  (mst_resps[p])
    );
  end

  // Ready lines for B and R come from the back-pressure process
  always_comb begin
    slv_req         = req_drv;
    slv_req.b_ready = b_rdy;
    slv_req.r_ready = r_rdy;
  end

  always_comb begin
    valid_bits      = '0;
    valid_bits[1:0] = {slv_resp.b_valid, slv_resp.r_valid};
    for (int p = 0; p < NUM_PORTS; p++) begin
      valid_bits[2+3*p +: 3] = {mst_reqs[p].aw_valid, mst_reqs[p].w_valid, mst_reqs[p].ar_valid};
    end
  end

  assign b_hs = slv_resp.b_valid && slv_req.b_ready;
  assign r_hs = slv_resp.r_valid && slv_req.r_ready;

  task automatic value_mismatch(input string name, input logic [63:0] exp_v,
                                input logic [63:0] act_v);
    $display("FAILED %s: expected %h actual %h", name, exp_v, act_v);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  task automatic protocol_error(input string what);
    $display("Error: %s", what);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  // The first edge only loads the reset values, checking starts on the second
  a_reset_quiet: assert property (@(posedge clk_i)
      (cycle_cnt >= 1 && cycle_cnt <= RST_CYCLES + 1) |-> (valid_bits == '0))
    else value_mismatch("reset", '0, 64'($sampled(valid_bits)));

  a_b_expected: assert property (@(posedge clk_i) disable iff (reset_i)
      b_hs |-> (b_head != b_tail))
    else protocol_error("B response arrived with no write outstanding");

  a_b_value: assert property (@(posedge clk_i) disable iff (reset_i)
      b_hs |-> (slv_resp.b == exp_b[b_head]))
    else value_mismatch(test_name, 64'($sampled(exp_b[b_head])), 64'($sampled(slv_resp.b)));

  a_r_expected: assert property (@(posedge clk_i) disable iff (reset_i)
      r_hs |-> (r_head != r_tail))
    else protocol_error("R beat arrived with no read outstanding");

  a_r_value: assert property (@(posedge clk_i) disable iff (reset_i)
      r_hs |-> (slv_resp.r == exp_r[r_head]))
    else value_mismatch(test_name, 64'($sampled(exp_r[r_head])), 64'($sampled(slv_resp.r)));

  always @(posedge clk_i) begin
    if (reset_i) begin
      b_head       <= '0;
      r_head       <= '0;
      b_count      <= 0;
      r_last_count <= 0;
    end else begin
      if (b_hs) begin
        b_head  <= b_head + 8'd1;
        b_count <= b_count + 1;
      end
      if (r_hs) begin
        r_head <= r_head + 8'd1;
        if (slv_resp.r.last) begin
          r_last_count <= r_last_count + 1;
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      $display("Timeout: traffic did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("=== FAIL ===");
      $fatal(1);
    end
  end

  // B and R ready toggle at random, held low in reset
  always @(negedge clk_i) begin
    b_rdy = !reset_i && (($random(rdy_seed) & 1) != 0);
    r_rdy = !reset_i && (($random(rdy_seed) & 1) != 0);
  end

  // Ports 0 to 2 own the 4 KiB windows of the low 16 KiB
  function automatic logic is_mapped(input logic [ADDR_WIDTH-1:0] addr);
    return (addr[31:14] == '0) && (addr[13:12] < NUM_PORTS);
  endfunction

  function automatic logic [DATA_WIDTH-1:0] fill_word(input logic [ADDR_WIDTH-1:0] addr);
    return addr * 32'h9E37_79B1;
  endfunction

  // Called on a falling edge and returns on one
  task automatic write_burst(input logic [ID_WIDTH-1:0] txn_id,
                             input logic [ADDR_WIDTH-1:0] txn_addr,
                             input logic [LEN_WIDTH-1:0] txn_len);
    logic [DATA_WIDTH-1:0] data;
    exp_b[b_tail].id   = txn_id;
    exp_b[b_tail].resp = is_mapped(txn_addr) ? RESP_OKAY : RESP_DECERR;
    b_tail             = b_tail + 8'd1;
    aw_issued++;
    req_drv.aw       = '{id: txn_id, addr: txn_addr, len: txn_len};
    req_drv.aw_valid = 1'b1;
    do @(posedge clk_i); while (!slv_resp.aw_ready);
    @(negedge clk_i);
    req_drv.aw_valid = 1'b0;
    for (int i = 0; i <= txn_len; i++) begin
      data = $random(seed);
      if (is_mapped(txn_addr)) begin
        shadow[txn_addr[13:2] + 12'(i)] = data;
      end
      req_drv.w       = '{data: data, strb: '1, last: (i == txn_len)};
      req_drv.w_valid = 1'b1;
      do @(posedge clk_i); while (!slv_resp.w_ready);
      @(negedge clk_i);
    end
    req_drv.w_valid = 1'b0;
  endtask

  task automatic read_burst(input logic [ID_WIDTH-1:0] txn_id,
                            input logic [ADDR_WIDTH-1:0] txn_addr,
                            input logic [LEN_WIDTH-1:0] txn_len);
    logic mapped;
    mapped = is_mapped(txn_addr);
    // Unmapped reads return zero data with DECERR on every beat
    for (int i = 0; i <= txn_len; i++) begin
      exp_r[r_tail].id   = txn_id;
      exp_r[r_tail].data = mapped ? shadow[txn_addr[13:2] + 12'(i)] : '0;
      exp_r[r_tail].resp = mapped ? RESP_OKAY : RESP_DECERR;
      exp_r[r_tail].last = (i == txn_len);
      r_tail             = r_tail + 8'd1;
    end
    ar_issued++;
    req_drv.ar       = '{id: txn_id, addr: txn_addr, len: txn_len};
    req_drv.ar_valid = 1'b1;
    do @(posedge clk_i); while (!slv_resp.ar_ready);
    @(negedge clk_i);
    req_drv.ar_valid = 1'b0;
  endtask

  // Waits until every issued burst has seen its B or its last R beat
  task automatic drain();
    while ((b_count != aw_issued) || (r_last_count != ar_issued)) begin
      @(negedge clk_i);
    end
  endtask

  initial begin
    logic [ADDR_WIDTH-1:0] mix_addr [0:29];
    logic [LEN_WIDTH-1:0]  mix_len  [0:29];
    logic [1:0]            port;
    req_drv   = '0;
    b_tail    = '0;
    r_tail    = '0;
    test_name = "reset";
    for (int a = 0; a < 4096; a++) begin
      shadow[a] = fill_word(32'(a) << 2);
    end
    repeat (RST_CYCLES) @(negedge clk_i);
    reset_i = 1'b0;
    repeat (3) @(negedge clk_i);

    test_name = "single";
    for (int p = 0; p < NUM_PORTS; p++) begin
      write_burst(4'(p), (32'(p) << 12) | 32'h40, 8'd0);
    end
    drain();
    for (int p = 0; p < NUM_PORTS; p++) begin
      read_burst(4'(p + 4), (32'(p) << 12) | 32'h40, 8'd0);
    end
    drain();

    test_name = "burst";
    for (int p = 0; p < NUM_PORTS; p++) begin
      write_burst(4'(p + 8), (32'(p) << 12) | 32'h200, 8'd3);
    end
    drain();
    for (int p = 0; p < NUM_PORTS; p++) begin
      read_burst(4'(p + 12), (32'(p) << 12) | 32'h200, 8'd3);
    end
    drain();

    // Port field 3 and an address above the low 16 KiB
    test_name = "decerr";
    write_burst(4'hA, 32'h0000_3010, 8'd1);
    write_burst(4'hB, 32'h0010_0000, 8'd0);
    read_burst(4'hC, 32'h0000_3010, 8'd2);
    read_burst(4'hD, 32'h0010_0000, 8'd2);
    drain();

    // Runs of four to one port, with a decode error every fifth request
    test_name = "mixed";
    for (int i = 0; i < 30; i++) begin
      port       = 2'((i / 4) % NUM_PORTS);
      mix_len[i] = 8'($random(seed) & 3);
      if ((i % 5) == 4) begin
        mix_addr[i] = (i % 2) ? 32'h0000_3000 : 32'h0100_0000;
      end else begin
        mix_addr[i] = {18'd0, port, 10'($random(seed)) & 10'h3F8, 2'b00};
      end
    end
    for (int i = 0; i < 30; i++) begin
      write_burst(4'(i), mix_addr[i], mix_len[i]);
    end
    drain();
    for (int i = 0; i < 30; i++) begin
      read_burst(4'(i + 3), mix_addr[i], mix_len[i]);
    end
    drain();

    // A quiet stretch lets any stray response show up before the totals are taken
    repeat (20) @(negedge clk_i);
    test_name = "count";
    a_b_count: assert (b_head == b_tail)
      else value_mismatch("B count", 64'(b_tail), 64'(b_head));
    a_r_count: assert (r_head == r_tail)
      else value_mismatch("R beat count", 64'(r_tail), 64'(r_head));
    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

/* axi_demux_top.f */
hw/axi_demux_pkg.sv
hw/axi_addr_decode.sv
hw/axi_demux_write.sv
hw/axi_demux_read.sv
hw/axi_err_slave.sv
hw/axi_demux_top.sv
sim/axi_mem_model.sv
sim/tb_axi_demux.sv
